/* cpu_core.f */
+incdir+include
src/isa_pkg.sv
src/pipe_pkg.sv
src/fetch_unit.sv
src/decoder.sv
src/regfile.sv
src/dispatch_stage.sv
src/alu_commit.sv
src/cpu_core.sv
verification/cpu_core_assert.sv
verification/cpu_core_tb.sv

/* include/cpu_defs_defs.svh */
`ifndef CPU_DEFS_DEFS_SVH
`define CPU_DEFS_DEFS_SVH

// Datapath and address width
`define CPU_XLEN 32

`define CPU_NREGS 32
`define CPU_REG_AW 5

// First fetch address
`define CPU_RESET_PC 32'h0000_0000

// Longest ack delay of the instruction memory
`define CPU_WB_MAX_WAIT 3

`endif

/* src/alu_commit.sv */
`include "cpu_defs_defs.svh"

module alu_commit (
    input  logic              clk,
    input  logic              arst_n_i,
    input  pipe_pkg::issue_t  issue_i,
    output pipe_pkg::commit_t ex_fwd_o,
    output pipe_pkg::commit_t commit_o
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [`CPU_XLEN-1:0]   result;
    logic                   wen;
    logic                   cm_valid_q;
    logic [`CPU_XLEN-1:0]   cm_pc_q;
    logic                   cm_wen_q;
    logic [`CPU_REG_AW-1:0] cm_rd_q;
    logic [`CPU_XLEN-1:0]   cm_wdata_q;

    always_comb begin
        case (issue_i.dec.op)
            OP_ADD, OP_ADDI: result = issue_i.a + issue_i.b;
            OP_SUB:          result = issue_i.a - issue_i.b;
            OP_AND:          result = issue_i.a & issue_i.b;
            OP_OR:           result = issue_i.a | issue_i.b;
            OP_XOR:          result = issue_i.a ^ issue_i.b;
            OP_SLL:          result = issue_i.a << issue_i.b[4:0];
            OP_SRL:          result = issue_i.a >> issue_i.b[4:0];
            OP_SLT: begin
                result = {{(`CPU_XLEN-1){1'b0}}, $signed(issue_i.a) < $signed(issue_i.b)};
            end
            OP_LUI:          result = issue_i.b;  // Decoder placed imm
            default:         result = '0;
        endcase
    end

    assign wen = issue_i.valid && issue_i.dec.wen;

    // Seen by dispatch in the same cycle
    assign ex_fwd_o = '{valid: issue_i.valid, pc: issue_i.pc, wen: wen,
                        rd: issue_i.dec.rd, wdata: wen ? result : '0};

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cm_valid_q <= 1'b0;
        end else begin
            cm_valid_q <= ex_fwd_o.valid;
        end
    end

    always_ff @(posedge clk) begin
        cm_pc_q    <= ex_fwd_o.pc;
        cm_wen_q   <= ex_fwd_o.wen;
        cm_rd_q    <= ex_fwd_o.rd;
        cm_wdata_q <= ex_fwd_o.wdata;
    end

    assign commit_o = '{valid: cm_valid_q, pc: cm_pc_q, wen: cm_wen_q,
                        rd: cm_rd_q, wdata: cm_wdata_q};

endmodule

/* src/cpu_core.sv */
`include "cpu_defs_defs.svh"

module cpu_core (
    input  logic              clk,
    input  logic              arst_n_i,
    output pipe_pkg::wb_req_t wb_req_o,
    input  pipe_pkg::wb_rsp_t wb_rsp_i,
    output pipe_pkg::commit_t commit_o
);
    import isa_pkg::*;
    import pipe_pkg::*;

    fetched_t               fetched;
    decoded_instr_t         dec;
    logic [`CPU_REG_AW-1:0] raddr_a;
    logic [`CPU_REG_AW-1:0] raddr_b;
    logic [`CPU_XLEN-1:0]   rdata_a;
    logic [`CPU_XLEN-1:0]   rdata_b;
    issue_t                 issue;
    commit_t                ex_fwd;
    commit_t                commit;

    fetch_unit u_fetch (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .wb_req_o (wb_req_o),
        .wb_rsp_i (wb_rsp_i),
        .fetched_o(fetched)
    );

    decoder u_decoder (.instr_i(fetched.instr), .dec_o(dec));

    regfile u_regfile (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .raddr_a_i(raddr_a),
        .raddr_b_i(raddr_b),
        .rdata_a_o(rdata_a),
        .rdata_b_o(rdata_b),
        .commit_i (commit)     // Write port
    );

    dispatch_stage u_dispatch (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .fetched_i(fetched),
        .dec_i    (dec),
        .rdata_a_i(rdata_a),
        .rdata_b_i(rdata_b),
        .raddr_a_o(raddr_a),
        .raddr_b_o(raddr_b),
        .ex_fwd_i (ex_fwd),
        .commit_i (commit),
        .issue_o  (issue)
    );

    alu_commit u_alu (
        .clk     (clk),
        .arst_n_i(arst_n_i),
        .issue_i (issue),
        .ex_fwd_o(ex_fwd),
        .commit_o(commit)
    );

    assign commit_o = commit;

endmodule

/* src/decoder.sv */
`include "cpu_defs_defs.svh"

module decoder (
    input  logic [`CPU_XLEN-1:0]    instr_i,
    output isa_pkg::decoded_instr_t dec_o
);
    import isa_pkg::*;

    localparam int unsigned EXT_W = `CPU_XLEN - IMM_W;

    logic [OPC_W-1:0]       opc;
    logic [IMM_W-1:0]       imm;
    logic [`CPU_REG_AW-1:0] rd;
    alu_op_e                op;

    assign opc = instr_i[OPC_LSB +: OPC_W];
    assign imm = instr_i[IMM_LSB +: IMM_W];
    assign rd  = instr_i[RD_LSB +: `CPU_REG_AW];

    // Codes above LUI behave as NOP
    assign op = (opc > OP_LUI) ? OP_NOP : alu_op_e'(opc);

    always_comb begin
        dec_o.op      = op;
        dec_o.rd      = rd;
        dec_o.rj      = instr_i[RJ_LSB +: `CPU_REG_AW];
        dec_o.rk      = instr_i[RK_LSB +: `CPU_REG_AW];
        dec_o.use_imm = (op == OP_ADDI) || (op == OP_LUI);

        if (op == OP_LUI) begin
            dec_o.imm = {imm, {EXT_W{1'b0}}};
        end else begin
            dec_o.imm = {{EXT_W{imm[IMM_W-1]}}, imm};
        end

        // r0 writes are dropped here
        dec_o.wen = (rd != '0) && (op != OP_NOP);
    end

endmodule

/* src/dispatch_stage.sv */
`include "cpu_defs_defs.svh"

module dispatch_stage (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  pipe_pkg::fetched_t      fetched_i,
    input  isa_pkg::decoded_instr_t dec_i,
    input  logic [`CPU_XLEN-1:0]    rdata_a_i,
    input  logic [`CPU_XLEN-1:0]    rdata_b_i,
    output logic [`CPU_REG_AW-1:0]  raddr_a_o,
    output logic [`CPU_REG_AW-1:0]  raddr_b_o,
    input  pipe_pkg::commit_t       ex_fwd_i,
    input  pipe_pkg::commit_t       commit_i,
    output pipe_pkg::issue_t        issue_o
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic                 issue_valid_q;
    logic [`CPU_XLEN-1:0] issue_pc_q;
    decoded_instr_t       issue_dec_q;
    logic [`CPU_XLEN-1:0] issue_a_q;
    logic [`CPU_XLEN-1:0] issue_b_q;
    logic [`CPU_XLEN-1:0] op_a;
    logic [`CPU_XLEN-1:0] op_b;

    // Youngest producer wins
    function automatic logic [`CPU_XLEN-1:0] pick_operand(
        input logic [`CPU_REG_AW-1:0] addr,
        input logic [`CPU_XLEN-1:0]   rf_data,
        input commit_t                ex,
        input commit_t                cm
    );
        if (ex.valid && ex.wen && ex.rd == addr) begin
            return ex.wdata;
        end
        if (cm.valid && cm.wen && cm.rd == addr) begin
            return cm.wdata;
        end
        return rf_data;
    endfunction

    assign raddr_a_o = dec_i.rj;
    assign raddr_b_o = dec_i.rk;

    assign op_a = pick_operand(dec_i.rj, rdata_a_i, ex_fwd_i, commit_i);
    assign op_b = dec_i.use_imm ? dec_i.imm
                                : pick_operand(dec_i.rk, rdata_b_i, ex_fwd_i, commit_i);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            issue_valid_q <= 1'b0;
        end else begin
            issue_valid_q <= fetched_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetched_i.valid) begin
            issue_pc_q  <= fetched_i.pc;
            issue_dec_q <= dec_i;
            issue_a_q   <= op_a;
            issue_b_q   <= op_b;
        end
    end

    assign issue_o = '{valid: issue_valid_q, pc: issue_pc_q, dec: issue_dec_q,
                       a: issue_a_q, b: issue_b_q};

endmodule

/* src/fetch_unit.sv */
`include "cpu_defs_defs.svh"

module fetch_unit (
    input  logic               clk,
    input  logic               arst_n_i,
    output pipe_pkg::wb_req_t  wb_req_o,
    input  pipe_pkg::wb_rsp_t  wb_rsp_i,
    output pipe_pkg::fetched_t fetched_o
);
    import pipe_pkg::*;

    localparam logic [`CPU_XLEN-1:0] PC_STEP = 4;

    fetch_state_e         state_q;
    fetch_state_e         state_d;
    logic [`CPU_XLEN-1:0] pc_q;
    logic                 req;
    logic                 done;
    logic                 fetch_valid_q;
    logic [`CPU_XLEN-1:0] fetch_pc_q;
    logic [`CPU_XLEN-1:0] fetch_instr_q;

    assign req  = (state_q == FETCH_WAIT);
    assign done = req && wb_rsp_i.ack;

    // One idle cycle between requests
    always_comb begin
        state_d = state_q;
        case (state_q)
            FETCH_IDLE: state_d = FETCH_WAIT;
            FETCH_WAIT: begin
                if (wb_rsp_i.ack) begin
                    state_d = FETCH_IDLE;
                end
            end
            default: state_d = FETCH_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q       <= FETCH_IDLE;
            pc_q          <= `CPU_RESET_PC;
            fetch_valid_q <= 1'b0;
        end else begin
            state_q       <= state_d;
            fetch_valid_q <= done;   // Single-cycle pulse
            if (done) begin
                pc_q <= pc_q + PC_STEP;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            fetch_pc_q    <= pc_q;
            fetch_instr_q <= wb_rsp_i.dat;
        end
    end

    // Read-only master
    assign wb_req_o = '{cyc: req, stb: req, we: 1'b0, adr: pc_q};

    assign fetched_o = '{valid: fetch_valid_q, pc: fetch_pc_q, instr: fetch_instr_q};

endmodule

/* src/isa_pkg.sv */
`include "cpu_defs_defs.svh"

package isa_pkg;

    // Instruction word layout
    localparam int unsigned OPC_W   = 4;
    localparam int unsigned OPC_LSB = 28;
    localparam int unsigned RD_LSB  = 23;
    localparam int unsigned RJ_LSB  = 18;
    localparam int unsigned RK_LSB  = 13;
    localparam int unsigned IMM_LSB = 0;
    localparam int unsigned IMM_W   = 12;

    typedef enum logic [OPC_W-1:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_XOR  = 4'd5,
        OP_SLL  = 4'd6,
        OP_SRL  = 4'd7,
        OP_SLT  = 4'd8,  // Signed
        OP_ADDI = 4'd9,
        OP_LUI  = 4'd10
    } alu_op_e;

    typedef struct packed {
        alu_op_e                op;
        logic [`CPU_REG_AW-1:0] rd;
        logic [`CPU_REG_AW-1:0] rj;
        logic [`CPU_REG_AW-1:0] rk;
        logic                   use_imm;
        logic [`CPU_XLEN-1:0]   imm;      // Already extended
        logic                   wen;
    } decoded_instr_t;

endpackage

/* src/pipe_pkg.sv */
`include "cpu_defs_defs.svh"

package pipe_pkg;

    // Wishbone classic, master to slave
    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [`CPU_XLEN-1:0] adr;
    } wb_req_t;

    typedef struct packed {
        logic                 ack;
        logic [`CPU_XLEN-1:0] dat;
    } wb_rsp_t;

    typedef enum logic {
        FETCH_IDLE,
        FETCH_WAIT
    } fetch_state_e;

    typedef struct packed {
        logic                 valid;
        logic [`CPU_XLEN-1:0] pc;
        logic [`CPU_XLEN-1:0] instr;
    } fetched_t;

    typedef struct packed {
        logic                    valid;
        logic [`CPU_XLEN-1:0]    pc;
        isa_pkg::decoded_instr_t dec;
        logic [`CPU_XLEN-1:0]    a;
        logic [`CPU_XLEN-1:0]    b;   // Imm when use_imm
    } issue_t;

    // Also the commit trace
    typedef struct packed {
        logic                   valid;
        logic [`CPU_XLEN-1:0]   pc;
        logic                   wen;
        logic [`CPU_REG_AW-1:0] rd;
        logic [`CPU_XLEN-1:0]   wdata;
    } commit_t;

endpackage

/* src/regfile.sv */
`include "cpu_defs_defs.svh"

module regfile (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic [`CPU_REG_AW-1:0] raddr_a_i,
    input  logic [`CPU_REG_AW-1:0] raddr_b_i,
    output logic [`CPU_XLEN-1:0]   rdata_a_o,
    output logic [`CPU_XLEN-1:0]   rdata_b_o,
    input  pipe_pkg::commit_t      commit_i
);

    // r0 has no storage
    logic [`CPU_XLEN-1:0] regs [1:`CPU_NREGS-1];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < `CPU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (commit_i.valid && commit_i.wen && commit_i.rd != '0) begin
            regs[commit_i.rd] <= commit_i.wdata;
        end
    end

    // No write-through, dispatch forwards the committing value
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

/* verification/cpu_core_assert.sv */
`include "cpu_defs_defs.svh"

module cpu_core_assert (
    input logic              clk,
    input logic              arst_n_i,
    input pipe_pkg::wb_req_t wb_req_i,
    input pipe_pkg::wb_rsp_t wb_rsp_i,
    input pipe_pkg::commit_t commit_i
);

    int unsigned fail_count = 0;

    stb_needs_cyc: assert property (@(posedge clk) disable iff (!arst_n_i)
        wb_req_i.stb |-> wb_req_i.cyc)
        else begin
            fail_count++;
            $error("stb high without cyc");
        end

    // Request held until the slave answers
    req_held: assert property (@(posedge clk) disable iff (!arst_n_i)
        (wb_req_i.stb && !wb_rsp_i.ack) |=> (wb_req_i.stb && $stable(wb_req_i.adr)))
        else begin
            fail_count++;
            $error("stb or adr changed before ack");
        end

    adr_aligned: assert property (@(posedge clk) disable iff (!arst_n_i)
        wb_req_i.cyc |-> (wb_req_i.adr[1:0] == 2'b00))
        else begin
            fail_count++;
            $error("fetch address not word aligned");
        end

    ack_in_time: assert property (@(posedge clk) disable iff (!arst_n_i)
        $rose(wb_req_i.stb) |-> ##[0:`CPU_WB_MAX_WAIT] wb_rsp_i.ack)
        else begin
            fail_count++;
            $error("no ack within the wait limit");
        end

    // Skips the first edge, before the reset state has settled
    reset_quiet: assert property (@(posedge clk)
        (!arst_n_i && !$past(arst_n_i)) |-> (!wb_req_i.cyc && !commit_i.valid))
        else begin
            fail_count++;
            $error("bus or commit active during reset");
        end

endmodule

bind cpu_core cpu_core_assert u_assert (
    .clk     (clk),
    .arst_n_i(arst_n_i),
    .wb_req_i(wb_req_o),
    .wb_rsp_i(wb_rsp_i),
    .commit_i(commit_o)
);

/* verification/cpu_core_tb.sv */
`include "cpu_defs_defs.svh"

module cpu_core_tb;
    import pipe_pkg::*;

    localparam int unsigned N_INSTR = 400;
    localparam int unsigned TIMEOUT = N_INSTR * (`CPU_WB_MAX_WAIT + 3) * 20 + 2000;

    logic                 clk;
    logic                 arst_n_i;
    wb_req_t              wb_req;
    wb_rsp_t              wb_rsp;
    commit_t              commit;
    integer               seed;
    int unsigned          commit_count;
    bit                   in_request;
    int unsigned          wait_left;
    logic [`CPU_XLEN-1:0] program_mem [N_INSTR];
    logic [`CPU_XLEN-1:0] model_regs [`CPU_NREGS];
    commit_t              expected [N_INSTR];

    cpu_core dut_i (
        .clk     (clk),
        .arst_n_i(arst_n_i),
        .wb_req_o(wb_req),
        .wb_rsp_i(wb_rsp),
        .commit_o(commit)
    );

    always #10 clk = ~clk;

    // Mostly r0..r3 so that neighbours depend on each other
    function automatic logic [`CPU_REG_AW-1:0] pick_reg();
        logic [31:0] r;
        r = $random(seed);
        if (r[1:0] != 2'b00) begin
            return {3'b000, r[3:2]};
        end
        return r[8:4];
    endfunction

    function automatic logic [`CPU_XLEN-1:0] random_instr();
        logic [31:0]            r;
        logic [3:0]             opc;
        logic [`CPU_REG_AW-1:0] rd;
        logic [`CPU_REG_AW-1:0] rj;
        logic [`CPU_REG_AW-1:0] rk;
        r = $random(seed);
        if (r[2:0] == 3'd0) begin
            opc = 4'd11 + 4'(r[10:3] % 5);   // Undefined code
        end else begin
            opc = 4'(r[10:3] % 11);
        end
        rd = pick_reg();
        rj = pick_reg();
        rk = pick_reg();
        return {opc, rd, rj, rk, r[23], r[31:20]};
    endfunction

    function automatic logic [`CPU_XLEN-1:0] mem_word(input logic [`CPU_XLEN-1:0] adr);
        if ((adr >> 2) < N_INSTR) begin
            return program_mem[adr >> 2];
        end
        return '0;   // NOP past the program
    endfunction

    // Reference execution in program order
    task automatic run_model();
        logic [`CPU_XLEN-1:0]   w;
        logic [`CPU_XLEN-1:0]   a;
        logic [`CPU_XLEN-1:0]   b;
        logic [`CPU_XLEN-1:0]   res;
        logic [3:0]             opc;
        logic [`CPU_REG_AW-1:0] rd;
        logic [11:0]            imm;
        logic                   wen;
        for (int i = 0; i < `CPU_NREGS; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < N_INSTR; i++) begin
            w   = program_mem[i];
            opc = w[31:28];
            rd  = w[27:23];
            imm = w[11:0];
            a   = model_regs[w[22:18]];
            b   = model_regs[w[17:13]];
            case (opc)
                4'd1:  res = a + b;
                4'd2:  res = a - b;
                4'd3:  res = a & b;
                4'd4:  res = a | b;
                4'd5:  res = a ^ b;
                4'd6:  res = a << b[4:0];
                4'd7:  res = a >> b[4:0];
                4'd8:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                4'd9:  res = a + {{20{imm[11]}}, imm};
                4'd10: res = {imm, 20'h0};
                default: res = '0;
            endcase
            wen = (opc >= 4'd1) && (opc <= 4'd10) && (rd != '0);
            expected[i] = '{valid: 1'b1, pc: `CPU_RESET_PC + 4 * i, wen: wen,
                            rd: rd, wdata: wen ? res : '0};
            if (wen) begin
                model_regs[rd] = res;
            end
        end
    endtask

    task automatic report_mismatch(input string name, input logic [`CPU_XLEN-1:0] got,
                                   input logic [`CPU_XLEN-1:0] exp);
        $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_commit(input commit_t got, input commit_t exp);
        if (got.pc !== exp.pc) report_mismatch("commit_o.pc", got.pc, exp.pc);
        if (got.wen !== exp.wen) report_mismatch("commit_o.wen", got.wen, exp.wen);
        if (got.rd !== exp.rd) report_mismatch("commit_o.rd", got.rd, exp.rd);
        if (got.wdata !== exp.wdata) report_mismatch("commit_o.wdata", got.wdata, exp.wdata);
    endtask

    task automatic check_reg(input int idx, input logic [`CPU_XLEN-1:0] got,
                             input logic [`CPU_XLEN-1:0] exp);
        if (got !== exp) begin
            report_mismatch($sformatf("u_regfile.regs[%0d]", idx), got, exp);
        end
    endtask

    task automatic check_regs();
        for (int i = 1; i < `CPU_NREGS; i++) begin
            check_reg(i, dut_i.u_regfile.regs[i], model_regs[i]);
        end
    endtask

    // Bound checker counts its own failures
    task automatic check_assertions();
        if (dut_i.u_assert.fail_count != 0) begin
            $display("Protocol or reset assertion failed before %0t", $time);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    // Memory slave, 0 to CPU_WB_MAX_WAIT wait states per request
    always @(negedge clk) begin
        wb_rsp.ack = 1'b0;
        if (arst_n_i && wb_req.cyc && wb_req.stb) begin
            if (!in_request) begin
                in_request = 1'b1;
                wait_left  = $unsigned($random(seed)) % (`CPU_WB_MAX_WAIT + 1);
            end
            if (wait_left == 0) begin
                wb_rsp.ack = 1'b1;
                wb_rsp.dat = mem_word(wb_req.adr);
                in_request = 1'b0;
            end else begin
                wait_left--;
            end
        end
    end

    initial begin
        clk          = 1'b0;
        arst_n_i     = 1'b0;
        wb_rsp       = '0;
        seed         = 54;
        commit_count = 0;
        in_request   = 1'b0;
        wait_left    = 0;
        for (int i = 0; i < N_INSTR; i++) begin
            program_mem[i] = random_instr();
        end
        run_model();
        repeat (5) @(negedge clk);
        arst_n_i = 1'b1;
        while (commit_count < N_INSTR) begin
            @(negedge clk);
            check_assertions();
            if (commit.valid) begin
                check_commit(commit, expected[commit_count]);
                commit_count++;
            end
        end
        @(negedge clk);   // Last write lands
        check_assertions();
        check_regs();
        $display("ALL CHECKS PASSED");
        $finish;
    end

    initial begin
        #(TIMEOUT);
        $display("Timeout: %0d of %0d instructions committed", commit_count, N_INSTR);
        $display("CHECKS FAILED");
        $fatal(1);
    end

endmodule
